// File: coreTypesPkg.sv
`default_nettype none

package coreTypesPkg;

    localparam int dataWidth = 32;
    localparam int tagWidth = 4;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSlt,
        opAddi,
        opAuipc,
        opMul
    } opT;

    typedef enum logic {
        unitAlu,
        unitMul
    } unitT;

    // operand still waiting on a producer tag
    typedef struct packed {
        logic [dataWidth-tagWidth-1:0] pad;
        logic [tagWidth-1:0]           tag;
    } tagWaitT;

    // ready bit next to it picks the view
    typedef union packed {
        logic [dataWidth-1:0] value;
        tagWaitT              pending;
    } operandU;

    typedef struct packed {
        logic    ready;
        operandU word;
    } operandT;

    typedef struct packed {
        opT                   op;
        unitT                 unit;
        logic [tagWidth-1:0]  dest;
        operandT              src1;
        operandT              src2;
        logic [dataWidth-1:0] imm;
        logic [dataWidth-1:0] pc;
    } issueT;

    typedef struct packed {
        opT                   op;
        logic [tagWidth-1:0]  dest;
        logic [dataWidth-1:0] val1;
        logic [dataWidth-1:0] val2;
        logic [dataWidth-1:0] imm;
        logic [dataWidth-1:0] pc;
    } dispatchT;

endpackage

`default_nettype wire

// File: cdbPkg.sv
`default_nettype none

package cdbPkg;

    import coreTypesPkg::*;

    // index 0 is the alu, index 1 the multiplier
    localparam int numRequesters = 2;
    localparam int grantPtrWidth = $clog2(numRequesters);

    typedef struct packed {
        logic                 valid;
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } cdbT;

endpackage

`default_nettype wire

// File: reservationStation.sv
`timescale 1ns/1ns
`default_nettype none

module reservationStation
    import coreTypesPkg::*;
    import cdbPkg::*;
#(
    parameter int   depth    = 4,
    parameter unitT unitKind = unitAlu
) (
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     flush,
    input  wire logic     issueValid,
    input  wire issueT    issue,
    input  wire cdbT      cdb,
    input  wire logic     unitBusy,
    output logic          full,
    output logic          dispatchValid,
    output dispatchT      dispatch
);

    logic [depth-1:0] busy;
    issueT            entries [depth];

    logic             freeFound;
    int unsigned      freeIdx;
    logic             selFound;
    int unsigned      selIdx;
    logic             acceptIssue;
    operandT          issueSrc1;
    operandT          issueSrc2;

    // capture a broadcast value if the tag matches
    function automatic operandT wake(operandT op, cdbT bus);
        operandT res;
        res = op;
        if (!op.ready && bus.valid && op.word.pending.tag == bus.tag) begin
            res.ready = 1'b1;
            res.word.value = bus.data;
        end
        return res;
    endfunction

    // lowest free slot and lowest ready slot
    always_comb begin
        freeFound = 1'b0;
        freeIdx = 0;
        selFound = 1'b0;
        selIdx = 0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                freeFound = 1'b1;
                freeIdx = i;
            end
            if (busy[i] && entries[i].src1.ready && entries[i].src2.ready) begin
                selFound = 1'b1;
                selIdx = i;
            end
        end
    end

    assign full = &busy;
    assign acceptIssue = issueValid && (issue.unit == unitKind) && freeFound;
    assign issueSrc1 = wake(issue.src1, cdb);
    assign issueSrc2 = wake(issue.src2, cdb);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= '0;
            dispatchValid <= 1'b0;
        end else if (flush) begin
            busy <= '0;
            dispatchValid <= 1'b0;
        end else begin
            // dispatch register holds while the unit is stalled
            if (!unitBusy) begin
                dispatchValid <= selFound;
                if (selFound) begin
                    busy[selIdx] <= 1'b0;
                end
            end
            if (acceptIssue) begin
                busy[freeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            if (busy[i]) begin
                entries[i].src1 <= wake(entries[i].src1, cdb);
                entries[i].src2 <= wake(entries[i].src2, cdb);
            end
        end
        if (acceptIssue) begin
            entries[freeIdx] <= issue;
            entries[freeIdx].src1 <= issueSrc1;
            entries[freeIdx].src2 <= issueSrc2;
        end
        if (!unitBusy && selFound) begin
            dispatch.op <= entries[selIdx].op;
            dispatch.dest <= entries[selIdx].dest;
            dispatch.val1 <= entries[selIdx].src1.word.value;
            dispatch.val2 <= entries[selIdx].src2.word.value;
            dispatch.imm <= entries[selIdx].imm;
            dispatch.pc <= entries[selIdx].pc;
        end
    end

endmodule

`default_nettype wire

// File: intAlu.sv
`timescale 1ns/1ns
`default_nettype none

module intAlu
    import coreTypesPkg::*;
    import cdbPkg::*;
(
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     flush,
    input  wire logic     dispatchValid,
    input  wire dispatchT dispatch,
    input  wire logic     grant,
    output logic          busy,
    output logic          req,
    output cdbT           result
);

    logic                 holdValid;
    logic [tagWidth-1:0]  holdTag;
    logic [dataWidth-1:0] holdData;
    logic [dataWidth-1:0] aluOut;
    logic                 sltBit;

    assign sltBit = $signed(dispatch.val1) < $signed(dispatch.val2);

    always_comb begin
        case (dispatch.op)
            opAdd:   aluOut = dispatch.val1 + dispatch.val2;
            opSub:   aluOut = dispatch.val1 - dispatch.val2;
            opAnd:   aluOut = dispatch.val1 & dispatch.val2;
            opOr:    aluOut = dispatch.val1 | dispatch.val2;
            opXor:   aluOut = dispatch.val1 ^ dispatch.val2;
            opSlt:   aluOut = {{(dataWidth-1){1'b0}}, sltBit};
            opAddi:  aluOut = dispatch.val1 + dispatch.imm;
            opAuipc: aluOut = dispatch.pc + dispatch.imm;
            default: aluOut = '0;
        endcase
    end

    // stalled while the held result waits for the bus
    assign busy = holdValid && !grant;
    assign req = holdValid;
    assign result = '{valid: holdValid, tag: holdTag, data: holdData};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            holdValid <= 1'b0;
        end else if (flush) begin
            holdValid <= 1'b0;
        end else if (!busy) begin
            holdValid <= dispatchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && dispatchValid) begin
            holdTag <= dispatch.dest;
            holdData <= aluOut;
        end
    end

endmodule

`default_nettype wire

// File: mulPipe.sv
`timescale 1ns/1ns
`default_nettype none

module mulPipe
    import coreTypesPkg::*;
    import cdbPkg::*;
(
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     flush,
    input  wire logic     dispatchValid,
    input  wire dispatchT dispatch,
    input  wire logic     grant,
    output logic          busy,
    output logic          req,
    output cdbT           result
);

    // low half of multiplier done in stage one
    typedef struct packed {
        logic [tagWidth-1:0]        tag;
        logic [dataWidth-1:0]       pp;
        logic [dataWidth-1:0]       a;
        logic [dataWidth/2-1:0]     bHi;
    } stageOneT;

    typedef struct packed {
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] pp;
    } stageT;

    logic [2:0] stageValid;
    stageOneT   s1;
    stageT      s2;
    stageT      s3;
    logic       stall;

    assign stall = stageValid[2] && !grant;
    assign busy = stall;
    assign req = stageValid[2];
    assign result = '{valid: stageValid[2], tag: s3.tag, data: s3.pp};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageValid <= '0;
        end else if (flush) begin
            stageValid <= '0;
        end else if (!stall) begin
            stageValid <= {stageValid[1:0], dispatchValid};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1.tag <= dispatch.dest;
            s1.pp <= dispatch.val1 * dataWidth'(dispatch.val2[dataWidth/2-1:0]);
            s1.a <= dispatch.val1;
            s1.bHi <= dispatch.val2[dataWidth-1:dataWidth/2];
            // upper half only reaches the low word shifted up
            s2.tag <= s1.tag;
            s2.pp <= s1.pp + ((s1.a * dataWidth'(s1.bHi)) << (dataWidth / 2));
            s3 <= s2;
        end
    end

endmodule

`default_nettype wire

// File: cdbArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cdbArbiter
    import cdbPkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     arstN,
    input  wire logic [numRequesters-1:0] req,
    input  wire cdbT  [numRequesters-1:0] results,
    output logic      [numRequesters-1:0] grant,
    output cdbT                           cdb
);

    logic [grantPtrWidth-1:0] lastGrant;
    logic [grantPtrWidth-1:0] winIdx;

    // search starts just past the last winner
    always_comb begin
        int unsigned idx;
        grant = '0;
        winIdx = lastGrant;
        for (int k = 1; k <= numRequesters; k++) begin
            idx = (int'(lastGrant) + k) % numRequesters;
            if (req[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                winIdx = grantPtrWidth'(idx);
            end
        end
    end

    always_comb begin
        cdb = '0;
        for (int i = 0; i < numRequesters; i++) begin
            if (grant[i]) begin
                cdb = results[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lastGrant <= '0;
        end else if (|grant) begin
            lastGrant <= winIdx;
        end
    end

endmodule

`default_nettype wire

// File: execCluster.sv
`timescale 1ns/1ns
`default_nettype none

module execCluster
    import coreTypesPkg::*;
    import cdbPkg::*;
(
    input  wire logic  clk,
    input  wire logic  arstN,
    input  wire logic  flush,
    input  wire logic  issueValid,
    input  wire issueT issue,
    output logic       aluFull,
    output logic       mulFull,
    output cdbT        cdb
);

    logic                     aluDispatchValid;
    dispatchT                 aluDispatch;
    logic                     aluBusy;
    logic                     mulDispatchValid;
    dispatchT                 mulDispatch;
    logic                     mulBusy;
    logic [numRequesters-1:0] req;
    logic [numRequesters-1:0] grant;
    cdbT  [numRequesters-1:0] results;

    reservationStation #(.depth(4), .unitKind(unitAlu)) aluStation (
        .clk, .arstN, .flush, .issueValid, .issue, .cdb,
        .unitBusy     (aluBusy),
        .full         (aluFull),
        .dispatchValid(aluDispatchValid),
        .dispatch     (aluDispatch)
    );

    reservationStation #(.depth(2), .unitKind(unitMul)) mulStation (
        .clk, .arstN, .flush, .issueValid, .issue, .cdb,
        .unitBusy     (mulBusy),
        .full         (mulFull),
        .dispatchValid(mulDispatchValid),
        .dispatch     (mulDispatch)
    );

    intAlu i_intAlu (
        .clk, .arstN, .flush,
        .dispatchValid(aluDispatchValid),
        .dispatch     (aluDispatch),
        .grant        (grant[0]),
        .busy         (aluBusy),
        .req          (req[0]),
        .result       (results[0])
    );

    mulPipe i_mulPipe (
        .clk, .arstN, .flush,
        .dispatchValid(mulDispatchValid),
        .dispatch     (mulDispatch),
        .grant        (grant[1]),
        .busy         (mulBusy),
        .req          (req[1]),
        .result       (results[1])
    );

    cdbArbiter i_cdbArbiter (
        .clk, .arstN, .req, .results, .grant, .cdb
    );

endmodule

`default_nettype wire

// File: tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected result of one instruction from its resolved operands
function automatic logic [31:0] refResult(
    input opT          op,
    input logic [31:0] a,
    input logic [31:0] b,
    input logic [31:0] imm,
    input logic [31:0] pc
);
    logic [63:0] prod;
    logic        aNeg;
    logic        bNeg;
    prod = '0;
    aNeg = a[31];
    bNeg = b[31];
    case (op)
        opAdd:   return a + b;
        opSub:   return a + ~b + 32'd1;
        opAnd:   return a & b;
        opOr:    return a | b;
        opXor:   return a ^ b;
        opSlt: begin
            // signs differ, so the negative one is smaller
            if (aNeg != bNeg) begin
                return aNeg ? 32'd1 : 32'd0;
            end
            return (a < b) ? 32'd1 : 32'd0;
        end
        opAddi:  return a + imm;
        opAuipc: return pc + imm;
        opMul: begin
            prod = {32'd0, a} * {32'd0, b};
            return prod[31:0];
        end
        default: return 32'd0;
    endcase
endfunction

`endif

// File: tbExecCluster.sv
`timescale 1ns/1ns
`default_nettype none

module tbExecCluster
    import coreTypesPkg::*;
    import cdbPkg::*;
;

    localparam int randomCount = 60;
    // directed sections issue this many on top of the random stream
    localparam int directedIssues = 37;
    localparam int plannedIssues = directedIssues + randomCount;
    localparam int resetCycles = 5;

    logic  clk;
    logic  arstN;
    logic  flush;
    logic  issueValid;
    issueT issue;
    logic  aluFull;
    logic  mulFull;
    cdbT   cdb;

    // scoreboard, one row per tag
    bit          pending [16];
    bit          known [16];
    logic [31:0] expVal [16];
    opT          eOp [16];
    logic [31:0] eA [16];
    logic [31:0] eB [16];
    logic [31:0] eImm [16];
    logic [31:0] ePc [16];
    bit          need1 [16];
    bit          need2 [16];
    logic [3:0]  prod1 [16];
    logic [3:0]  prod2 [16];

    `include "tbRefModel.svh"

    execCluster i_execCluster (
        .clk, .arstN, .flush, .issueValid, .issue, .aluFull, .mulFull, .cdb
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #((resetCycles + 40 * plannedIssues) * 4);
        $display("run timed out waiting for results");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // result still owed by the DUT, or on the bus right now
    function automatic bit inFlight(input logic [3:0] t);
        return pending[t] || (cdb.valid && cdb.tag == t);
    endfunction

    function automatic bit anyPending();
        for (int i = 0; i < 16; i++) begin
            if (pending[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    always @(negedge clk) begin
        if (arstN && cdb.valid) begin
            assert (pending[cdb.tag]) else begin
                $display("broadcast of tag %0d that was not pending at %0t ns", cdb.tag, $time);
                $display(">>> FAIL");
                $fatal(1, "unexpected broadcast");
            end
            assert (known[cdb.tag] && cdb.data == expVal[cdb.tag]) else begin
                $display("error at %0t ns: tag %0d data %h expected %h",
                         $time, cdb.tag, cdb.data, expVal[cdb.tag]);
                $display(">>> FAIL");
                $fatal(1, "data mismatch");
            end
            pending[cdb.tag] = 1'b0;
        end
    end

    task automatic waitRoom(input opT op);
        while ((op == opMul) ? mulFull : aluFull) begin
            @(negedge clk);
        end
    endtask

    // also let the last broadcast leave the bus
    task automatic waitDrain();
        while (anyPending() || cdb.valid) begin
            @(negedge clk);
        end
    endtask

    task automatic allocTag(output logic [3:0] t);
        logic [3:0] start;
        bit         found;
        found = 1'b0;
        t = '0;
        while (!found) begin
            start = 4'($urandom % 16);
            for (int k = 0; k < 16; k++) begin
                if (!found && !inFlight(start + 4'(k))) begin
                    found = 1'b1;
                    t = start + 4'(k);
                end
            end
            if (!found) begin
                @(negedge clk);
            end
        end
    endtask

    // fill in consumers that waited on a producer issued later
    task automatic resolveWaiters(input logic [3:0] p);
        for (int i = 0; i < 16; i++) begin
            if (pending[i] && !known[i]) begin
                if (need1[i] && prod1[i] == p) begin
                    eA[i] = expVal[p];
                    need1[i] = 1'b0;
                end
                if (need2[i] && prod2[i] == p) begin
                    eB[i] = expVal[p];
                    need2[i] = 1'b0;
                end
                if (!need1[i] && !need2[i]) begin
                    known[i] = 1'b1;
                    expVal[i] = refResult(eOp[i], eA[i], eB[i], eImm[i], ePc[i]);
                end
            end
        end
    endtask

    task automatic issueInstr(
        input opT op, input logic [3:0] dest,
        input bit w1, input logic [3:0] p1, input logic [31:0] v1,
        input bit w2, input logic [3:0] p2, input logic [31:0] v2,
        input logic [31:0] imm, input logic [31:0] pc
    );
        issueT iss;
        waitRoom(op);
        iss = '0;
        iss.op = op;
        iss.unit = (op == opMul) ? unitMul : unitAlu;
        iss.dest = dest;
        iss.src1.ready = !w1;
        iss.src2.ready = !w2;
        if (w1) iss.src1.word.pending.tag = p1;
        else iss.src1.word.value = v1;
        if (w2) iss.src2.word.pending.tag = p2;
        else iss.src2.word.value = v2;
        iss.imm = imm;
        iss.pc = pc;
        eOp[dest] = op;
        eImm[dest] = imm;
        ePc[dest] = pc;
        need1[dest] = w1 && !(inFlight(p1) && known[p1]);
        need2[dest] = w2 && !(inFlight(p2) && known[p2]);
        prod1[dest] = p1;
        prod2[dest] = p2;
        eA[dest] = w1 ? expVal[p1] : v1;
        eB[dest] = w2 ? expVal[p2] : v2;
        known[dest] = !need1[dest] && !need2[dest];
        if (known[dest]) begin
            expVal[dest] = refResult(op, eA[dest], eB[dest], imm, pc);
        end
        pending[dest] = 1'b1;
        if (known[dest]) begin
            resolveWaiters(dest);
        end
        issue = iss;
        issueValid = 1'b1;
        @(negedge clk);
        issueValid = 1'b0;
    endtask

    task automatic issueReady(input opT op);
        logic [3:0] t;
        allocTag(t);
        issueInstr(op, t, 0, 0, $urandom, 0, 0, $urandom, $urandom, $urandom);
    endtask

    task automatic checkFull(input bit expAlu, input bit expMul);
        assert (aluFull == expAlu && mulFull == expMul) else begin
            $display("error at %0t ns: full flags alu %b mul %b expected %b %b",
                     $time, aluFull, mulFull, expAlu, expMul);
            $display(">>> FAIL");
            $fatal(1, "full flag mismatch");
        end
    endtask

    task automatic randomStream();
        logic [3:0] t;
        logic [3:0] p;
        bit         w [2];
        logic [3:0] pt [2];
        opT         op;
        for (int n = 0; n < randomCount; n++) begin
            allocTag(t);
            op = ($urandom % 3 == 0) ? opMul : opT'(4'($urandom % 8));
            waitRoom(op);
            for (int s = 0; s < 2; s++) begin
                p = 4'($urandom % 16);
                w[s] = ($urandom % 2 == 1) && p != t && inFlight(p) && known[p];
                pt[s] = p;
            end
            issueInstr(op, t, w[0], pt[0], $urandom, w[1], pt[1], $urandom, $urandom, $urandom);
        end
    endtask

    initial begin
        logic [3:0] a;
        logic [3:0] b;
        logic [3:0] c;
        void'($urandom(32'ha3e94f1b));
        arstN = 1'b0;
        flush = 1'b0;
        issueValid = 1'b0;
        issue = '0;
        for (int i = 0; i < 16; i++) begin
            pending[i] = 1'b0;
            known[i] = 1'b0;
            expVal[i] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkFull(0, 0);

        // every alu op with ready operands
        for (int k = 0; k < 8; k++) begin
            issueReady(opT'(4'(k)));
        end
        waitDrain();

        // back to back multiplies
        repeat (6) issueReady(opMul);
        waitDrain();

        // chain through the bus
        allocTag(a);
        issueInstr(opMul, a, 0, 0, $urandom, 0, 0, $urandom, 0, 0);
        allocTag(b);
        issueInstr(opAdd, b, inFlight(a), a, expVal[a], 0, 0, $urandom, 0, 0);
        allocTag(c);
        issueInstr(opSub, c, inFlight(b), b, expVal[b], inFlight(a), a, expVal[a], 0, 0);
        waitDrain();
        // consumer issued in the producer's broadcast cycle
        allocTag(a);
        issueInstr(opXor, a, 0, 0, $urandom, 0, 0, $urandom, 0, 0);
        while (!(cdb.valid && cdb.tag == a)) @(negedge clk);
        allocTag(b);
        issueInstr(opAddi, b, 1, a, 0, 0, 0, 0, $urandom, 0);
        waitDrain();

        randomStream();
        waitDrain();

        // blocked entries fill both stations
        for (int k = 0; k < 4; k++) begin
            checkFull(0, 0);
            issueInstr(opOr, 4'(k), 1, 4'd4, 0, 0, 0, $urandom, 0, 0);
        end
        checkFull(1, 0);
        issueInstr(opMul, 4'd4, 0, 0, $urandom, 0, 0, $urandom, 0, 0);
        waitDrain();
        issueInstr(opMul, 4'd5, 1, 4'd7, 0, 0, 0, $urandom, 0, 0);
        checkFull(0, 0);
        issueInstr(opMul, 4'd6, 0, 0, $urandom, 1, 4'd7, 0, 0, 0);
        checkFull(0, 1);
        issueInstr(opSlt, 4'd7, 0, 0, $urandom, 0, 0, $urandom, 0, 0);
        waitDrain();

        // flush with work in flight
        repeat (3) issueReady(opMul);
        repeat (3) issueReady(opAdd);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < 16; i++) begin
            pending[i] = 1'b0;
        end
        repeat (20) @(negedge clk);
        checkFull(0, 0);
        repeat (2) issueReady(opMul);
        repeat (2) issueReady(opAuipc);
        waitDrain();
        repeat (5) @(negedge clk);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
coreTypesPkg.sv
cdbPkg.sv
reservationStation.sv
intAlu.sv
mulPipe.sv
cdbArbiter.sv
execCluster.sv
tbExecCluster.sv

// File: runSim.sh
#!/bin/sh
# build and run the execution cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tbExecCluster \
    --Mdir obj_dir -o simExecCluster > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/simExecCluster > sim.log 2>&1
simStatus=$?

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
echo "simulation failed (status $simStatus), see sim.log"
exit 1
